/* filelist.f */
+incdir+source
+incdir+test
source/exec_pkg.sv
source/issue_router.sv
source/int_alu.sv
source/iter_multiplier.sv
source/completion_arbiter.sv
source/completion_core.sv
test/completion_core_tb.sv

/* run.sh */
#!/bin/sh
# build and run the completion core testbench with Verilator
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module completion_core_tb \
  -f filelist.f -o completion_core_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/completion_core_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit $status
fi

exit 0

/* test/completion_vectors.svh */
/*
 * stimulus table for the completion core testbench
 * one row per issued operation, with its expected CDB value
 */

`ifndef COMPLETION_VECTORS_SVH
`define COMPLETION_VECTORS_SVH

// columns: opcode, tag, a, b, expected value, random operands
// rows flagged random get a and b from $random, want is then unused
typedef struct packed {
  fu_op_t op;
  tag_t   tag;
  data_t  a;
  data_t  b;
  data_t  want;
  logic   rand_ops;
} vector_t;

localparam int num_vectors = 24;

localparam vector_t vectors [num_vectors] = '{
  '{op_add, 6'd0,  32'h0000_0005, 32'h0000_0007, 32'h0000_000C, 1'b0},
  '{op_sub, 6'd2,  32'h0000_0003, 32'h0000_000A, 32'hFFFF_FFF9, 1'b0},
  '{op_and, 6'd3,  32'hF0F0_1234, 32'h0FF0_FF00, 32'h00F0_1200, 1'b0},
  '{op_or,  6'd4,  32'hF000_000F, 32'h0A00_0030, 32'hFA00_003F, 1'b0},
  '{op_xor, 6'd5,  32'hFFFF_0000, 32'h0F0F_0F0F, 32'hF0F0_0F0F, 1'b0},
  '{op_shl, 6'd6,  32'h0000_0001, 32'h0000_001F, 32'h8000_0000, 1'b0},
  // shift counts above 31, only the low 5 bits count
  '{op_shl, 6'd7,  32'h1234_5678, 32'h0000_0024, 32'h2345_6780, 1'b0},
  '{op_shr, 6'd8,  32'h8000_0000, 32'h0000_0004, 32'h0800_0000, 1'b0},
  '{op_shr, 6'd9,  32'hDEAD_BEEF, 32'h0000_0028, 32'h00DE_ADBE, 1'b0},
  '{op_slt, 6'd10, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0001, 1'b0},
  '{op_slt, 6'd11, 32'h0000_0005, 32'h8000_0000, 32'h0000_0000, 1'b0},
  // multiply then a burst of ALU ops fighting for the bus
  '{op_mul, 6'd12, 32'h0000_0006, 32'h0000_0007, 32'h0000_002A, 1'b0},
  '{op_add, 6'd13, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0000, 1'b0},
  '{op_sub, 6'd14, 32'h0000_0064, 32'h0000_0001, 32'h0000_0063, 1'b0},
  '{op_xor, 6'd15, 32'hAAAA_5555, 32'hFFFF_FFFF, 32'h5555_AAAA, 1'b0},
  '{op_or,  6'd16, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 1'b0},
  // back-to-back multiplies, second one waits on the unit
  '{op_mul, 6'd17, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0001, 1'b0},
  '{op_mul, 6'd18, 32'h0001_0000, 32'h0001_0000, 32'h0000_0000, 1'b0},
  '{op_mul, 6'd19, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 1'b1},
  '{op_add, 6'd20, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 1'b1},
  '{op_slt, 6'd21, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 1'b1},
  '{op_mul, 6'd22, 32'h0000_FFFF, 32'h0000_FFFF, 32'hFFFE_0001, 1'b0},
  '{op_mul, 6'd23, 32'h1234_5678, 32'h0000_0010, 32'h2345_6780, 1'b0},
  '{op_sub, 6'd63, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 1'b1}
};

`endif

/* test/completion_core_tb.sv */
/*
 * testbench for the completion core
 * clock and reset, four-phase issue driver, CDB monitor,
 * handshake order check, value checker and cycle limit
 */

`include "exec_defs.svh"

module completion_core_tb;
  import exec_pkg::*;

  `include "completion_vectors.svh"

  localparam int num_tags  = 1 << `EXEC_TAG_W;
  localparam int max_cycle = num_vectors * 40 + 100;

  logic   clock;
  logic   reset;
  logic   issue_req;
  fu_op_t issue_op;
  tag_t   issue_tag;
  data_t  issue_a;
  data_t  issue_b;
  logic   issue_ack;
  logic   cdb_valid;
  tag_t   cdb_tag;
  data_t  cdb_value;

  // per-tag bookkeeping, filled at issue, drained by the monitor
  logic    issued [num_tags];
  data_t   want_value [num_tags];
  int      beat_count [num_tags];
  int      received;
  int      cycle_count;
  integer  seed;
  logic    prev_req;
  logic    prev_ack;
  vector_t row;

  completion_core dut (
    .clock(clock), .reset(reset),
    .issue_req(issue_req), .issue_op(issue_op), .issue_tag(issue_tag),
    .issue_a(issue_a), .issue_b(issue_b), .issue_ack(issue_ack),
    .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value)
  );

  always #5 clock = ~clock;

  //////////////////////////////////////////////////////////////////////
  // reference rules and checker
  //////////////////////////////////////////////////////////////////////

  // expected result straight from the opcode rules
  function automatic data_t model_result(input fu_op_t op, input data_t a, input data_t b);
    logic [2*`EXEC_DATA_W-1:0] product;
    product = {{`EXEC_DATA_W{1'b0}}, a} * {{`EXEC_DATA_W{1'b0}}, b};
    case (op)
      op_add:  return a + b;
      op_sub:  return a - b;
      op_and:  return a & b;
      op_or:   return a | b;
      op_xor:  return a ^ b;
      op_shl:  return a << b[4:0];
      op_shr:  return a >> b[4:0];
      op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      // low word of the full product
      default: return product[`EXEC_DATA_W-1:0];
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      $display("[FAIL] t=%0t %s: got %h expected %h", $time, name, got, want);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // monitors
  //////////////////////////////////////////////////////////////////////

  // each CDB beat must belong to an issued tag, once, with its value
  always @(posedge clock) begin
    if (!reset && cdb_valid) begin
      check_value($sformatf("issued flag of cdb_tag %0d", cdb_tag),
                  32'(issued[cdb_tag]), 32'd1);
      check_value($sformatf("earlier beats for tag %0d", cdb_tag),
                  32'(beat_count[cdb_tag]), 32'd0);
      check_value($sformatf("cdb_value for tag %0d", cdb_tag),
                  cdb_value, want_value[cdb_tag]);
      beat_count[cdb_tag] = beat_count[cdb_tag] + 1;
      received = received + 1;
    end
  end

  // ack edges must follow the req level of the cycle before
  always @(posedge clock) begin
    if (!reset) begin
      if (issue_ack && !prev_ack) begin
        check_value("issue_req before issue_ack rise", 32'(prev_req), 32'd1);
      end
      if (!issue_ack && prev_ack) begin
        check_value("issue_req before issue_ack fall", 32'(prev_req), 32'd0);
      end
    end
    prev_req = issue_req;
    prev_ack = issue_ack;
  end

  // run limit
  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > max_cycle) begin
      $display("timeout: no finish after %0d cycles, %0d of %0d results seen",
               max_cycle, received, num_vectors);
      $display("TEST FAILED");
      $fatal(1);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    clock       = 1'b0;
    reset       = 1'b1;
    issue_req   = 1'b0;
    issue_op    = op_add;
    issue_tag   = '0;
    issue_a     = '0;
    issue_b     = '0;
    received    = 0;
    cycle_count = 0;
    prev_req    = 1'b0;
    prev_ack    = 1'b0;
    seed        = 32'ha812_c285;
    for (int t = 0; t < num_tags; t++) begin
      issued[t]     = 1'b0;
      want_value[t] = '0;
      beat_count[t] = 0;
    end

    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    check_value("issue_ack after reset", 32'(issue_ack), 32'd0);
    check_value("cdb_valid after reset", 32'(cdb_valid), 32'd0);

    for (int i = 0; i < num_vectors; i++) begin
      row = vectors[i];
      if (row.rand_ops) begin
        row.a    = $random(seed);
        row.b    = $random(seed);
        row.want = model_result(row.op, row.a, row.b);
      end
      issued[row.tag]     = 1'b1;
      want_value[row.tag] = row.want;
      // phase one, fields stable with req
      issue_req = 1'b1;
      issue_op  = row.op;
      issue_tag = row.tag;
      issue_a   = row.a;
      issue_b   = row.b;
      while (!issue_ack) begin
        @(posedge clock);
        #1;
      end
      // phase three, then wait for ack to drop
      issue_req = 1'b0;
      while (issue_ack) begin
        @(posedge clock);
        #1;
      end
      // idle cycle after a multiply so a later ALU result meets its completion
      if (row.op == op_mul) begin
        @(posedge clock);
        #1;
      end
    end

    while (received < num_vectors) begin
      @(posedge clock);
      #1;
    end
    // a few idle cycles to catch stray beats
    repeat (12) @(posedge clock);
    #1;
    for (int i = 0; i < num_vectors; i++) begin
      check_value($sformatf("beats for tag %0d", vectors[i].tag),
                  32'(beat_count[vectors[i].tag]), 32'd1);
    end
    $display("TEST OK");
    $finish;
  end

endmodule

/* source/completion_core.sv */
/*
 * top of the execute and complete path
 * issue router, two ALUs, multiplier, completion arbiter
 */

`include "exec_defs.svh"

module completion_core (
  input  logic             clock,
  input  logic             reset,
  input  logic             issue_req,
  input  exec_pkg::fu_op_t issue_op,
  input  exec_pkg::tag_t   issue_tag,
  input  exec_pkg::data_t  issue_a,
  input  exec_pkg::data_t  issue_b,
  output logic             issue_ack,
  output logic             cdb_valid,
  output exec_pkg::tag_t   cdb_tag,
  output exec_pkg::data_t  cdb_value
);

  // router to units
  logic             alu0_start, alu1_start, mul_start;
  exec_pkg::fu_op_t op_q;
  exec_pkg::tag_t   tag_q;
  exec_pkg::data_t  a_q, b_q;

  // units back to router
  logic alu0_free, alu1_free, mul_free;

  // units to arbiter
  logic            alu0_done, alu1_done, mul_done;
  exec_pkg::tag_t  alu0_tag, alu1_tag, mul_tag;
  exec_pkg::data_t alu0_value, alu1_value, mul_value;
  logic            alu0_grant, alu1_grant, mul_grant;

  //////////////////////////////////////////////////////////////////////
  // issue
  //////////////////////////////////////////////////////////////////////

  issue_router router (
    .clock(clock), .reset(reset),
    .issue_req(issue_req), .issue_op(issue_op), .issue_tag(issue_tag),
    .issue_a(issue_a), .issue_b(issue_b),
    .alu0_free(alu0_free), .alu1_free(alu1_free), .mul_free(mul_free),
    .issue_ack(issue_ack),
    .alu0_start(alu0_start), .alu1_start(alu1_start), .mul_start(mul_start),
    .op_q(op_q), .tag_q(tag_q), .a_q(a_q), .b_q(b_q)
  );

  //////////////////////////////////////////////////////////////////////
  // execution units
  //////////////////////////////////////////////////////////////////////

  int_alu alu0 (
    .clock(clock), .reset(reset), .start(alu0_start),
    .op(op_q), .tag(tag_q), .a(a_q), .b(b_q), .grant(alu0_grant),
    .free(alu0_free), .done(alu0_done),
    .done_tag(alu0_tag), .done_value(alu0_value)
  );

  int_alu alu1 (
    .clock(clock), .reset(reset), .start(alu1_start),
    .op(op_q), .tag(tag_q), .a(a_q), .b(b_q), .grant(alu1_grant),
    .free(alu1_free), .done(alu1_done),
    .done_tag(alu1_tag), .done_value(alu1_value)
  );

  // multiplier ignores op, only op_mul is steered here
  iter_multiplier mul (
    .clock(clock), .reset(reset), .start(mul_start),
    .tag(tag_q), .a(a_q), .b(b_q), .grant(mul_grant),
    .free(mul_free), .done(mul_done),
    .done_tag(mul_tag), .done_value(mul_value)
  );

  //////////////////////////////////////////////////////////////////////
  // completion
  //////////////////////////////////////////////////////////////////////

  completion_arbiter arbiter (
    .clock(clock), .reset(reset),
    .mul_done(mul_done), .alu0_done(alu0_done), .alu1_done(alu1_done),
    .mul_tag(mul_tag), .alu0_tag(alu0_tag), .alu1_tag(alu1_tag),
    .mul_value(mul_value), .alu0_value(alu0_value), .alu1_value(alu1_value),
    .mul_grant(mul_grant), .alu0_grant(alu0_grant), .alu1_grant(alu1_grant),
    .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value)
  );

endmodule

/* source/completion_arbiter.sv */
/*
 * completion arbiter
 * fixed priority multiplier > alu0 > alu1, winner muxed onto the
 * registered CDB
 */

`include "exec_defs.svh"

module completion_arbiter (
  input  logic            clock,
  input  logic            reset,
  input  logic            mul_done,
  input  logic            alu0_done,
  input  logic            alu1_done,
  input  exec_pkg::tag_t  mul_tag,
  input  exec_pkg::tag_t  alu0_tag,
  input  exec_pkg::tag_t  alu1_tag,
  input  exec_pkg::data_t mul_value,
  input  exec_pkg::data_t alu0_value,
  input  exec_pkg::data_t alu1_value,
  output logic            mul_grant,
  output logic            alu0_grant,
  output logic            alu1_grant,
  output logic            cdb_valid,
  output exec_pkg::tag_t  cdb_tag,
  output exec_pkg::data_t cdb_value
);
  import exec_pkg::*;

  tag_t  sel_tag;
  data_t sel_value;
  logic  any_done;

  //////////////////////////////////////////////////////////////////////
  // grant
  //////////////////////////////////////////////////////////////////////

  // long-latency unit first so it frees up soonest
  assign mul_grant  = mul_done;
  assign alu0_grant = alu0_done & ~mul_done;
  assign alu1_grant = alu1_done & ~mul_done & ~alu0_done;

  assign any_done = mul_done | alu0_done | alu1_done;

  // winner select, follows the grant order
  always_comb begin
    if (mul_done) begin
      sel_tag   = mul_tag;
      sel_value = mul_value;
    end else if (alu0_done) begin
      sel_tag   = alu0_tag;
      sel_value = alu0_value;
    end else begin
      sel_tag   = alu1_tag;
      sel_value = alu1_value;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // CDB register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= any_done;
    end
  end

  // one beat per cycle, the cycle after the grant
  always_ff @(posedge clock) begin
    if (any_done) begin
      cdb_tag   <= sel_tag;
      cdb_value <= sel_value;
    end
  end

endmodule

/* source/iter_multiplier.sv */
/*
 * multi-cycle shift-and-add multiplier
 * idle/run/hold FSM, one step of multiplier bits per cycle,
 * low word of the product held until the bus grants it
 */

`include "exec_defs.svh"

module iter_multiplier (
  input  logic            clock,
  input  logic            reset,
  input  logic            start,
  input  exec_pkg::tag_t  tag,
  input  exec_pkg::data_t a,
  input  exec_pkg::data_t b,
  input  logic            grant,
  output logic            free,
  output logic            done,
  output exec_pkg::tag_t  done_tag,
  output exec_pkg::data_t done_value
);
  import exec_pkg::*;

  // enough to count every step
  typedef logic [$clog2(`MUL_STEPS+1)-1:0] cnt_t;

  mul_state_t state;
  cnt_t       step_cnt;
  data_t      mcand_q;
  data_t      mplier_q;
  data_t      acc_q;
  data_t      mcand_src;
  data_t      mplier_src;
  data_t      acc_src;
  data_t      acc_next;
  logic       last_step;

  //////////////////////////////////////////////////////////////////////
  // step datapath
  //////////////////////////////////////////////////////////////////////

  // first step runs straight off the issued operands
  assign mcand_src  = (state == mul_idle) ? a : mcand_q;
  assign mplier_src = (state == mul_idle) ? b : mplier_q;
  assign acc_src    = (state == mul_idle) ? '0 : acc_q;

  // partial product of one digit, only the low word is kept
  assign acc_next = acc_src + mcand_src *
                    {{(`EXEC_DATA_W-`MUL_STEP_BITS){1'b0}},
                     mplier_src[`MUL_STEP_BITS-1:0]};

  assign last_step = (step_cnt == cnt_t'(`MUL_STEPS - 1));

  //////////////////////////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= mul_idle;
      step_cnt <= '0;
    end else begin
      case (state)
        mul_idle: begin
          if (start) begin
            state    <= mul_run;
            step_cnt <= cnt_t'(1);
          end
        end
        mul_run: begin
          step_cnt <= step_cnt + cnt_t'(1);
          if (last_step) begin
            state <= mul_hold;
          end
        end
        mul_hold: begin
          // result leaves on the grant edge
          if (grant) begin
            state <= mul_idle;
          end
        end
        default: state <= mul_idle;
      endcase
    end
  end

  // operand shifters and accumulator, frozen in hold
  always_ff @(posedge clock) begin
    if ((state == mul_idle && start) || state == mul_run) begin
      acc_q    <= acc_next;
      mcand_q  <= mcand_src << `MUL_STEP_BITS;
      mplier_q <= mplier_src >> `MUL_STEP_BITS;
    end
    if (state == mul_idle && start) begin
      done_tag <= tag;
    end
  end

  assign free       = (state == mul_idle);
  assign done       = (state == mul_hold);
  assign done_value = acc_q;

endmodule

/* source/int_alu.sv */
/*
 * single-cycle integer unit
 * add/sub, logic ops, shifts, signed compare, result held for the CDB
 */

`include "exec_defs.svh"

module int_alu (
  input  logic             clock,
  input  logic             reset,
  input  logic             start,
  input  exec_pkg::fu_op_t op,
  input  exec_pkg::tag_t   tag,
  input  exec_pkg::data_t  a,
  input  exec_pkg::data_t  b,
  input  logic             grant,
  output logic             free,
  output logic             done,
  output exec_pkg::tag_t   done_tag,
  output exec_pkg::data_t  done_value
);
  import exec_pkg::*;

  data_t result;
  logic  less;

  // signed compare for slt
  assign less = ($signed(a) < $signed(b));

  always_comb begin
    case (op)
      op_add:  result = a + b;
      op_sub:  result = a - b;
      op_and:  result = a & b;
      op_or:   result = a | b;
      op_xor:  result = a ^ b;
      // shift count from the low 5 bits of b
      op_shl:  result = a << b[4:0];
      op_shr:  result = a >> b[4:0];
      op_slt:  result = {{(`EXEC_DATA_W-1){1'b0}}, less};
      // multiply never routed here
      default: result = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // held result
  //////////////////////////////////////////////////////////////////////

  // busy from the result edge until the bus takes it
  assign free = ~done;

  always_ff @(posedge clock) begin
    if (reset) begin
      done <= 1'b0;
    end else if (start) begin
      done <= 1'b1;
    end else if (grant) begin
      done <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      done_tag   <= tag;
      done_value <= result;
    end
  end

endmodule

/* source/issue_router.sv */
/*
 * issue side of the execute path
 * four-phase req/ack acceptance, unit selection, start pulses
 */

`include "exec_defs.svh"

module issue_router (
  input  logic             clock,
  input  logic             reset,
  input  logic             issue_req,
  input  exec_pkg::fu_op_t issue_op,
  input  exec_pkg::tag_t   issue_tag,
  input  exec_pkg::data_t  issue_a,
  input  exec_pkg::data_t  issue_b,
  input  logic             alu0_free,
  input  logic             alu1_free,
  input  logic             mul_free,
  output logic             issue_ack,
  output logic             alu0_start,
  output logic             alu1_start,
  output logic             mul_start,
  output exec_pkg::fu_op_t op_q,
  output exec_pkg::tag_t   tag_q,
  output exec_pkg::data_t  a_q,
  output exec_pkg::data_t  b_q
);
  import exec_pkg::*;

  logic is_mul;
  logic target_free;
  logic accept;

  assign is_mul = (issue_op == op_mul);

  // alu0 preferred, alu1 only when alu0 is taken
  assign target_free = is_mul ? mul_free : (alu0_free | alu1_free);

  // new request only while ack is low
  assign accept = issue_req & ~issue_ack & target_free;

  //////////////////////////////////////////////////////////////////////
  // handshake and start pulses
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      issue_ack  <= 1'b0;
      alu0_start <= 1'b0;
      alu1_start <= 1'b0;
      mul_start  <= 1'b0;
    end else begin
      // one-cycle pulse into the chosen unit
      alu0_start <= accept & ~is_mul & alu0_free;
      alu1_start <= accept & ~is_mul & ~alu0_free;
      mul_start  <= accept & is_mul;
      // ack held until the requester lets go
      if (accept) begin
        issue_ack <= 1'b1;
      end else if (!issue_req) begin
        issue_ack <= 1'b0;
      end
    end
  end

  // operation fields, broadcast to all units
  always_ff @(posedge clock) begin
    if (accept) begin
      op_q  <= issue_op;
      tag_q <= issue_tag;
      a_q   <= issue_a;
      b_q   <= issue_b;
    end
  end

endmodule

/* source/exec_pkg.sv */
/*
 * shared types for the execute and complete path
 * data word, register tag, unit opcodes, multiplier states
 */

`include "exec_defs.svh"

package exec_pkg;

  //////////////////////////////////////////////////////////////////////
  // payload types
  //////////////////////////////////////////////////////////////////////

  // operand or result word
  typedef logic [`EXEC_DATA_W-1:0] data_t;

  // destination physical register
  typedef logic [`EXEC_TAG_W-1:0] tag_t;

  //////////////////////////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////////////////////////

  // opcodes seen by the units, op_mul goes to the multiplier
  typedef enum logic [3:0] {
    op_add = 4'd0,
    op_sub = 4'd1,
    op_and = 4'd2,
    op_or  = 4'd3,
    op_xor = 4'd4,
    op_shl = 4'd5,
    op_shr = 4'd6,
    op_slt = 4'd7,
    op_mul = 4'd8
  } fu_op_t;

  // multiplier control
  typedef enum logic [1:0] {
    mul_idle = 2'd0,
    mul_run  = 2'd1,
    mul_hold = 2'd2
  } mul_state_t;

endpackage

/* source/exec_defs.svh */
/*
 * widths shared by the execute and complete path
 * operand/result word, physical register tag, multiplier stepping
 */

`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// datapath
//////////////////////////////////////////////////////////////////////

// one operand or result word
`define EXEC_DATA_W 32

// physical register tag, 64 registers
`define EXEC_TAG_W 6

//////////////////////////////////////////////////////////////////////
// multiplier
//////////////////////////////////////////////////////////////////////

// multiplier bits retired per cycle
`define MUL_STEP_BITS 4

// iterations for a full word
`define MUL_STEPS (`EXEC_DATA_W / `MUL_STEP_BITS)

`endif
